//--- hw/aib_lane_pkg.sv
`default_nettype none

package aib_lane_pkg;

    //////////////////////////////
    // channel geometry
    //////////////////////////////
    localparam int LANES_DEFAULT = 40;  // data lanes per phase

    //////////////////////////////
    // configuration bus
    //////////////////////////////
    localparam int CSR_ADDR_W = 17;     // byte address
    localparam int CSR_DATA_W = 32;
    localparam int CSR_BE_W   = 4;
    localparam int CH_ID_W    = 6;
    localparam int CH_ID_LSB  = 11;     // addr[16:11] selects the channel

    // word index within the channel window, addr[10:2]
    localparam int REG_IDX_LSB = 2;
    localparam int REG_IDX_W   = 9;

    // register word indices
    localparam logic [REG_IDX_W-1:0] REG_TX_SHIFT_LO = 9'd0;  // tx mask 31:0
    localparam logic [REG_IDX_W-1:0] REG_TX_SHIFT_HI = 9'd1;  // tx mask LANES:32
    localparam logic [REG_IDX_W-1:0] REG_RX_SHIFT_LO = 9'd2;  // rx mask 31:0
    localparam logic [REG_IDX_W-1:0] REG_RX_SHIFT_HI = 9'd3;  // rx mask LANES:32
    localparam logic [REG_IDX_W-1:0] REG_ADAPT_CTRL  = 9'd4;  // loopback in 1:0

    //////////////////////////////
    // loopback select
    //////////////////////////////
    // code 3 is not listed and falls through as no loopback
    typedef enum logic [1:0] {
        LPBK_NONE     = 2'd0,
        LPBK_FARSIDE  = 2'd1,  // received pads go straight back out
        LPBK_NEARSIDE = 2'd2   // transmit words feed the receiver
    } lpbk_mode_t;

endpackage

`default_nettype wire

//--- hw/aib_csr_regs.sv
`timescale 1ns/1ps
`default_nettype none

module aib_csr_regs #(
    parameter int LANES = 40
) (
    input  wire                                 i_m_wr_clk,
    input  wire                                 i_rst_n,
    input  wire  [aib_lane_pkg::CH_ID_W-1:0]    i_channel_id,
    input  wire  [aib_lane_pkg::CSR_ADDR_W-1:0] i_cfg_avmm_addr,
    input  wire  [aib_lane_pkg::CSR_BE_W-1:0]   i_cfg_avmm_byte_en,
    input  wire                                 i_cfg_avmm_read,
    input  wire                                 i_cfg_avmm_write,
    input  wire  [aib_lane_pkg::CSR_DATA_W-1:0] i_cfg_avmm_wdata,
    output logic [aib_lane_pkg::CSR_DATA_W-1:0] o_cfg_avmm_rdata,
    output logic                                o_cfg_avmm_rdatavld,
    output logic                                o_cfg_avmm_waitreq,
    output logic [LANES:0]                      o_tx_shift_en,
    output logic [LANES:0]                      o_rx_shift_en,
    output aib_lane_pkg::lpbk_mode_t            o_lpbk_mode
);
    import aib_lane_pkg::*;

    // implemented bits of a LO/HI mask pair, LANES+1 ones
    localparam logic [2*CSR_DATA_W-1:0] SHIFT_IMPL = {(2*CSR_DATA_W){1'b1}} >> (63 - LANES);
    localparam logic [CSR_DATA_W-1:0]   IMPL_LO    = SHIFT_IMPL[CSR_DATA_W-1:0];
    localparam logic [CSR_DATA_W-1:0]   IMPL_HI    = SHIFT_IMPL[2*CSR_DATA_W-1:CSR_DATA_W];
    localparam logic [CSR_DATA_W-1:0]   IMPL_CTRL  = 32'h0000_0003;

    logic                  ch_hit;
    logic [REG_IDX_W-1:0]  reg_idx;
    logic                  rd_pend;    // read seen, accept next cycle
    logic                  rd_accept;
    logic                  wr_en;
    logic [CSR_DATA_W-1:0] rd_mux;
    logic [CSR_DATA_W-1:0] tx_lo_q, tx_hi_q, rx_lo_q, rx_hi_q, ctrl_q;

    // byte-enabled update restricted to the implemented bits
    function automatic logic [CSR_DATA_W-1:0] be_merge(
        input logic [CSR_DATA_W-1:0] cur,
        input logic [CSR_DATA_W-1:0] wdata,
        input logic [CSR_BE_W-1:0]   be,
        input logic [CSR_DATA_W-1:0] impl
    );
        logic [CSR_DATA_W-1:0] wmask;
        for (int b = 0; b < CSR_BE_W; b++) begin
            wmask[8*b +: 8] = {8{be[b]}};
        end
        wmask = wmask & impl;
        return (cur & ~wmask) | (wdata & wmask);
    endfunction

    assign ch_hit  = (i_cfg_avmm_addr[CH_ID_LSB +: CH_ID_W] == i_channel_id);
    assign reg_idx = i_cfg_avmm_addr[REG_IDX_LSB +: REG_IDX_W];

    assign o_cfg_avmm_waitreq = i_cfg_avmm_read & ~rd_pend;  // one wait state per read
    assign rd_accept          = i_cfg_avmm_read & rd_pend;
    assign wr_en              = i_cfg_avmm_write & ~o_cfg_avmm_waitreq & ch_hit;

    always_comb begin
        case (reg_idx)
            REG_TX_SHIFT_LO: rd_mux = tx_lo_q;
            REG_TX_SHIFT_HI: rd_mux = tx_hi_q;
            REG_RX_SHIFT_LO: rd_mux = rx_lo_q;
            REG_RX_SHIFT_HI: rd_mux = rx_hi_q;
            REG_ADAPT_CTRL:  rd_mux = ctrl_q;
            default:         rd_mux = '0;   // unmapped
        endcase
        if (!ch_hit) begin
            rd_mux = '0;                    // other channel reads zero
        end
    end

    //////////////////////////////
    // read sequencer
    //////////////////////////////
    always_ff @(posedge i_m_wr_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_pend             <= 1'b0;
            o_cfg_avmm_rdatavld <= 1'b0;
            o_cfg_avmm_rdata    <= '0;
        end else begin
            rd_pend             <= o_cfg_avmm_waitreq;
            o_cfg_avmm_rdatavld <= rd_accept;
            if (rd_accept) begin
                o_cfg_avmm_rdata <= rd_mux;
            end
        end
    end

    //////////////////////////////
    // register file
    //////////////////////////////
    always_ff @(posedge i_m_wr_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tx_lo_q <= '0;
            tx_hi_q <= '0;
            rx_lo_q <= '0;
            rx_hi_q <= '0;
            ctrl_q  <= '0;
        end else if (wr_en) begin
            case (reg_idx)
                REG_TX_SHIFT_LO: tx_lo_q <= be_merge(tx_lo_q, i_cfg_avmm_wdata,
                                                     i_cfg_avmm_byte_en, IMPL_LO);
                REG_TX_SHIFT_HI: tx_hi_q <= be_merge(tx_hi_q, i_cfg_avmm_wdata,
                                                     i_cfg_avmm_byte_en, IMPL_HI);
                REG_RX_SHIFT_LO: rx_lo_q <= be_merge(rx_lo_q, i_cfg_avmm_wdata,
                                                     i_cfg_avmm_byte_en, IMPL_LO);
                REG_RX_SHIFT_HI: rx_hi_q <= be_merge(rx_hi_q, i_cfg_avmm_wdata,
                                                     i_cfg_avmm_byte_en, IMPL_HI);
                REG_ADAPT_CTRL:  ctrl_q  <= be_merge(ctrl_q, i_cfg_avmm_wdata,
                                                     i_cfg_avmm_byte_en, IMPL_CTRL);
                default: ;                  // writes to holes dropped
            endcase
        end
    end

    assign o_tx_shift_en = (LANES+1)'({tx_hi_q, tx_lo_q});
    assign o_rx_shift_en = (LANES+1)'({rx_hi_q, rx_lo_q});
    assign o_lpbk_mode   = lpbk_mode_t'(ctrl_q[1:0]);

endmodule

`default_nettype wire

//--- hw/aib_tx_path.sv
`timescale 1ns/1ps
`default_nettype none

module aib_tx_path #(
    parameter int LANES = 40
) (
    input  wire               i_m_wr_clk,
    input  wire               i_rst_n,
    input  wire               i_conf_done,
    input  wire [2*LANES-1:0] i_data_in,
    input  wire [LANES:0]     i_tx_shift_en,
    output logic [LANES:0]    o_tx0,
    output logic [LANES:0]    o_tx1
);

    logic [LANES-1:0] ph0, ph1;     // even / odd phase lanes
    logic [LANES:0]   rep0, rep1;   // repaired bump words

    // bump j carries lane j-1 when shifted, else lane j
    function automatic logic [LANES:0] tx_repair(
        input logic [LANES-1:0] lanes,
        input logic [LANES:0]   shift
    );
        logic [LANES+1:0] ext;
        logic [LANES:0]   bumps;
        ext = {1'b0, lanes, 1'b0};  // lane -1 and lane LANES read as zero
        for (int j = 0; j <= LANES; j++) begin
            bumps[j] = shift[j] ? ext[j] : ext[j+1];
        end
        return bumps;
    endfunction

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            ph0[i] = i_data_in[2*i];
            ph1[i] = i_data_in[2*i+1];
        end
    end

    assign rep0 = tx_repair(ph0, i_tx_shift_en);
    assign rep1 = tx_repair(ph1, i_tx_shift_en);

    //////////////////////////////
    // pad launch register
    //////////////////////////////
    always_ff @(posedge i_m_wr_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_tx0 <= '0;
            o_tx1 <= '0;
        end else if (!i_conf_done) begin
            o_tx0 <= '0;    // quiet pads until configured
            o_tx1 <= '0;
        end else begin
            o_tx0 <= rep0;
            o_tx1 <= rep1;
        end
    end

endmodule

`default_nettype wire

//--- hw/aib_rx_path.sv
`timescale 1ns/1ps
`default_nettype none

module aib_rx_path #(
    parameter int LANES = 40
) (
    input  wire                 i_m_wr_clk,
    input  wire                 i_rst_n,
    input  wire                 i_conf_done,
    input  wire  [LANES:0]      i_rx0,
    input  wire  [LANES:0]      i_rx1,
    input  wire  [LANES:0]      i_rx_shift_en,
    output logic [2*LANES-1:0]  o_data_out
);

    logic [LANES-1:0]   lane0, lane1;   // repaired phase lanes
    logic [2*LANES-1:0] merged;

    // lane i takes bump i+1 when shifted, else bump i
    function automatic logic [LANES-1:0] rx_repair(
        input logic [LANES:0] bumps,
        input logic [LANES:0] shift
    );
        logic [LANES-1:0] lanes;
        for (int i = 0; i < LANES; i++) begin
            lanes[i] = shift[i] ? bumps[i+1] : bumps[i];
        end
        return lanes;
    endfunction

    assign lane0 = rx_repair(i_rx0, i_rx_shift_en);
    assign lane1 = rx_repair(i_rx1, i_rx_shift_en);

    // interleave back, even phase on even bits
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            merged[2*i]   = lane0[i];
            merged[2*i+1] = lane1[i];
        end
    end

    //////////////////////////////
    // read word register
    //////////////////////////////
    always_ff @(posedge i_m_wr_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_data_out <= '0;
        end else if (!i_conf_done) begin
            o_data_out <= '0;   // held off until configured
        end else begin
            o_data_out <= merged;
        end
    end

endmodule

`default_nettype wire

//--- hw/aib_pad_mux.sv
`timescale 1ns/1ps
`default_nettype none

module aib_pad_mux #(
    parameter int LANES = 40
) (
    input  wire                           i_m_wr_clk,
    input  wire                           i_rst_n,
    input  wire aib_lane_pkg::lpbk_mode_t i_lpbk_mode,
    input  wire  [LANES:0]                i_tx0,
    input  wire  [LANES:0]                i_tx1,
    input  wire  [LANES:0]                i_pad_rx0,
    input  wire  [LANES:0]                i_pad_rx1,
    output logic [LANES:0]                o_pad_tx0,
    output logic [LANES:0]                o_pad_tx1,
    output logic [LANES:0]                o_rx0,
    output logic [LANES:0]                o_rx1
);
    import aib_lane_pkg::*;

    logic           near_sel;   // receiver listens to own transmitter
    logic           far_sel;    // transmitter echoes the receiver
    logic [LANES:0] cap0_q, cap1_q;

    assign near_sel = (i_lpbk_mode == LPBK_NEARSIDE);
    assign far_sel  = (i_lpbk_mode == LPBK_FARSIDE);

    //////////////////////////////
    // pad capture
    //////////////////////////////
    always_ff @(posedge i_m_wr_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cap0_q <= '0;
            cap1_q <= '0;
        end else if (near_sel) begin
            cap0_q <= i_tx0;
            cap1_q <= i_tx1;
        end else begin
            cap0_q <= i_pad_rx0;
            cap1_q <= i_pad_rx1;
        end
    end

    assign o_rx0 = cap0_q;
    assign o_rx1 = cap1_q;

    // farside echo adds no cycle beyond the capture
    assign o_pad_tx0 = far_sel ? cap0_q : i_tx0;
    assign o_pad_tx1 = far_sel ? cap1_q : i_tx1;

endmodule

`default_nettype wire

//--- hw/aib_lane_channel.sv
`timescale 1ns/1ps
`default_nettype none

module aib_lane_channel #(
    parameter int LANES = aib_lane_pkg::LANES_DEFAULT
) (
    input  wire                                 i_m_wr_clk,
    input  wire                                 i_rst_n,
    input  wire                                 i_conf_done,
    input  wire  [aib_lane_pkg::CH_ID_W-1:0]    i_channel_id,

    // configuration bus
    input  wire  [aib_lane_pkg::CSR_ADDR_W-1:0] i_cfg_avmm_addr,
    input  wire  [aib_lane_pkg::CSR_BE_W-1:0]   i_cfg_avmm_byte_en,
    input  wire                                 i_cfg_avmm_read,
    input  wire                                 i_cfg_avmm_write,
    input  wire  [aib_lane_pkg::CSR_DATA_W-1:0] i_cfg_avmm_wdata,
    output logic [aib_lane_pkg::CSR_DATA_W-1:0] o_cfg_avmm_rdata,
    output logic                                o_cfg_avmm_rdatavld,
    output logic                                o_cfg_avmm_waitreq,

    // mac side
    input  wire  [2*LANES-1:0]                  i_data_in,
    output logic [2*LANES-1:0]                  o_data_out,

    // bump side, one spare bump per phase
    input  wire  [LANES:0]                      i_pad_rx0,
    input  wire  [LANES:0]                      i_pad_rx1,
    output logic [LANES:0]                      o_pad_tx0,
    output logic [LANES:0]                      o_pad_tx1
);
    import aib_lane_pkg::*;

    logic [LANES:0] tx_shift_en, rx_shift_en;
    lpbk_mode_t     lpbk_mode;
    logic [LANES:0] tx0, tx1;   // repaired, registered transmit words
    logic [LANES:0] rx0, rx1;   // captured receive source

    aib_csr_regs #(.LANES(LANES)) u_csr (
        .i_m_wr_clk          (i_m_wr_clk),
        .i_rst_n             (i_rst_n),
        .i_channel_id        (i_channel_id),
        .i_cfg_avmm_addr     (i_cfg_avmm_addr),
        .i_cfg_avmm_byte_en  (i_cfg_avmm_byte_en),
        .i_cfg_avmm_read     (i_cfg_avmm_read),
        .i_cfg_avmm_write    (i_cfg_avmm_write),
        .i_cfg_avmm_wdata    (i_cfg_avmm_wdata),
        .o_cfg_avmm_rdata    (o_cfg_avmm_rdata),
        .o_cfg_avmm_rdatavld (o_cfg_avmm_rdatavld),
        .o_cfg_avmm_waitreq  (o_cfg_avmm_waitreq),
        .o_tx_shift_en       (tx_shift_en),
        .o_rx_shift_en       (rx_shift_en),
        .o_lpbk_mode         (lpbk_mode)
    );

    aib_tx_path #(.LANES(LANES)) u_tx (
        .i_m_wr_clk    (i_m_wr_clk),
        .i_rst_n       (i_rst_n),
        .i_conf_done   (i_conf_done),
        .i_data_in     (i_data_in),
        .i_tx_shift_en (tx_shift_en),
        .o_tx0         (tx0),
        .o_tx1         (tx1)
    );

    aib_pad_mux #(.LANES(LANES)) u_pad (
        .i_m_wr_clk  (i_m_wr_clk),
        .i_rst_n     (i_rst_n),
        .i_lpbk_mode (lpbk_mode),
        .i_tx0       (tx0),
        .i_tx1       (tx1),
        .i_pad_rx0   (i_pad_rx0),
        .i_pad_rx1   (i_pad_rx1),
        .o_pad_tx0   (o_pad_tx0),
        .o_pad_tx1   (o_pad_tx1),
        .o_rx0       (rx0),
        .o_rx1       (rx1)
    );

    aib_rx_path #(.LANES(LANES)) u_rx (
        .i_m_wr_clk    (i_m_wr_clk),
        .i_rst_n       (i_rst_n),
        .i_conf_done   (i_conf_done),
        .i_rx0         (rx0),
        .i_rx1         (rx1),
        .i_rx_shift_en (rx_shift_en),
        .o_data_out    (o_data_out)
    );

endmodule

`default_nettype wire

//--- tb/tb_aib_lane_channel.sv
`timescale 1ns/1ps
`default_nettype none

module tb_aib_lane_channel;
    import aib_lane_pkg::*;

    localparam int LANES     = 40;
    localparam int BUMPS     = LANES + 1;
    localparam int WORD      = 2 * LANES;
    localparam int BUS_LIMIT = 16;      // cycles a bus transfer may stall

    localparam int MODE_OFF    = 0;     // outputs not compared
    localparam int MODE_DIRECT = 1;     // tx and rx repair, no loopback
    localparam int MODE_NEAR   = 2;
    localparam int MODE_FAR    = 3;

    logic                  i_m_wr_clk;
    logic                  i_rst_n;
    logic                  i_conf_done;
    logic [CH_ID_W-1:0]    i_channel_id;
    logic [CSR_ADDR_W-1:0] i_cfg_avmm_addr;
    logic [CSR_BE_W-1:0]   i_cfg_avmm_byte_en;
    logic                  i_cfg_avmm_read;
    logic                  i_cfg_avmm_write;
    logic [CSR_DATA_W-1:0] i_cfg_avmm_wdata;
    logic [CSR_DATA_W-1:0] o_cfg_avmm_rdata;
    logic                  o_cfg_avmm_rdatavld;
    logic                  o_cfg_avmm_waitreq;
    logic [WORD-1:0]       i_data_in;
    logic [WORD-1:0]       o_data_out;
    logic [LANES:0]        i_pad_rx0, i_pad_rx1;
    logic [LANES:0]        o_pad_tx0, o_pad_tx1;

    logic [31:0]     lfsr_state;
    int              errors, checks, err_mark;
    int              chk_mode, last_mode, warm;
    logic [LANES:0]  exp_tx_mask, exp_rx_mask;
    logic [WORD-1:0] h_data [0:2];      // index 0 sampled at the current edge
    logic [LANES:0]  h_rx0 [0:1];
    logic [LANES:0]  h_rx1 [0:1];
    logic            h_conf [0:2];

    aib_lane_channel #(.LANES(LANES)) UUT (
        .i_m_wr_clk          (i_m_wr_clk),
        .i_rst_n             (i_rst_n),
        .i_conf_done         (i_conf_done),
        .i_channel_id        (i_channel_id),
        .i_cfg_avmm_addr     (i_cfg_avmm_addr),
        .i_cfg_avmm_byte_en  (i_cfg_avmm_byte_en),
        .i_cfg_avmm_read     (i_cfg_avmm_read),
        .i_cfg_avmm_write    (i_cfg_avmm_write),
        .i_cfg_avmm_wdata    (i_cfg_avmm_wdata),
        .o_cfg_avmm_rdata    (o_cfg_avmm_rdata),
        .o_cfg_avmm_rdatavld (o_cfg_avmm_rdatavld),
        .o_cfg_avmm_waitreq  (o_cfg_avmm_waitreq),
        .i_data_in           (i_data_in),
        .o_data_out          (o_data_out),
        .i_pad_rx0           (i_pad_rx0),
        .i_pad_rx1           (i_pad_rx1),
        .o_pad_tx0           (o_pad_tx0),
        .o_pad_tx1           (o_pad_tx1)
    );

    always #10 i_m_wr_clk = ~i_m_wr_clk;   // 20 ns period

    //////////////////////////////
    // random source
    //////////////////////////////
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        if (s[0]) begin
            n = (s >> 1) ^ 32'h8020_0003;  // taps 32 22 2 1
        end else begin
            n = s >> 1;
        end
        return n;
    endfunction

    function automatic logic [WORD-1:0] rand_bits(input int n);
        logic [WORD-1:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v[b]       = lfsr_state[0];
        end
        return v;
    endfunction

    //////////////////////////////
    // reference model
    //////////////////////////////
    function automatic logic [LANES-1:0] split_phase(input logic [WORD-1:0] w, input int ph);
        logic [LANES-1:0] l;
        for (int i = 0; i < LANES; i++) begin
            l[i] = w[2*i+ph];
        end
        return l;
    endfunction

    function automatic logic [WORD-1:0] merge_phases(input logic [LANES-1:0] l0,
                                                     input logic [LANES-1:0] l1);
        logic [WORD-1:0] w;
        for (int i = 0; i < LANES; i++) begin
            w[2*i]   = l0[i];
            w[2*i+1] = l1[i];
        end
        return w;
    endfunction

    function automatic logic [LANES:0] tx_bump_map(input logic [LANES-1:0] lanes,
                                                   input logic [LANES:0]   m);
        logic [LANES:0] b;
        for (int j = 0; j <= LANES; j++) begin
            b[j] = 1'b0;                    // missing neighbour lanes read as zero
            if (m[j] && j > 0) begin
                b[j] = lanes[j-1];
            end else if (!m[j] && j < LANES) begin
                b[j] = lanes[j];
            end
        end
        return b;
    endfunction

    function automatic logic [LANES-1:0] rx_lane_map(input logic [LANES:0] b,
                                                     input logic [LANES:0] m);
        logic [LANES-1:0] l;
        for (int i = 0; i < LANES; i++) begin
            l[i] = m[i] ? b[i+1] : b[i];
        end
        return l;
    endfunction

    function automatic logic [31:0] byte_update(input logic [31:0] old, input logic [31:0] wd,
                                                input logic [3:0] be, input logic [31:0] impl);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                r[8*b +: 8] = wd[8*b +: 8];
            end
        end
        return r & impl;
    endfunction

    function automatic logic [31:0] impl_bits(input int idx);
        logic [31:0] m;
        case (idx)
            0, 2:    m = 32'hffff_ffff;
            1, 3:    m = 32'((64'h1 << (LANES - 31)) - 64'h1);  // mask bits LANES..32
            4:       m = 32'h0000_0003;
            default: m = 32'h0;
        endcase
        return m;
    endfunction

    function automatic logic [CSR_ADDR_W-1:0] make_addr(input logic [CH_ID_W-1:0] ch,
                                                        input int idx);
        return {ch, REG_IDX_W'(idx), 2'b00};
    endfunction

    task automatic compare_value(input string name, input logic [WORD-1:0] got,
                                 input logic [WORD-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    //////////////////////////////
    // bus tasks
    //////////////////////////////
    task automatic write_reg(input logic [CH_ID_W-1:0] ch, input int idx,
                             input logic [31:0] wd, input logic [3:0] be);
        int waits;
        @(negedge i_m_wr_clk);
        i_cfg_avmm_addr    = make_addr(ch, idx);
        i_cfg_avmm_byte_en = be;
        i_cfg_avmm_wdata   = wd;
        i_cfg_avmm_write   = 1'b1;
        waits = 0;
        #1;
        while (o_cfg_avmm_waitreq && waits < BUS_LIMIT) begin
            @(negedge i_m_wr_clk);
            #1;
            waits++;
        end
        if (o_cfg_avmm_waitreq) begin
            errors++;
            $display("write to index %0d was never accepted, waitreq stuck high", idx);
        end else if (waits != 0) begin
            errors++;
            $display("write to index %0d was held off by waitreq for %0d cycles", idx, waits);
        end
        @(negedge i_m_wr_clk);              // accept edge has passed
        i_cfg_avmm_write = 1'b0;
    endtask

    task automatic read_reg(input logic [CH_ID_W-1:0] ch, input int idx,
                            output logic [31:0] rd);
        int waits;
        @(negedge i_m_wr_clk);
        i_cfg_avmm_addr    = make_addr(ch, idx);
        i_cfg_avmm_byte_en = 4'hf;
        i_cfg_avmm_read    = 1'b1;
        waits = 0;
        #1;
        while (o_cfg_avmm_waitreq && waits < BUS_LIMIT) begin
            @(negedge i_m_wr_clk);
            #1;
            waits++;
        end
        if (o_cfg_avmm_waitreq) begin
            errors++;
            $display("read of index %0d was never accepted, waitreq stuck high", idx);
        end else if (waits != 1) begin
            errors++;
            $display("read of index %0d took %0d wait cycles instead of one", idx, waits);
        end
        if (o_cfg_avmm_rdatavld) begin
            errors++;
            $display("rdatavld rose before the read of index %0d was accepted", idx);
        end
        @(negedge i_m_wr_clk);
        i_cfg_avmm_read = 1'b0;
        if (!o_cfg_avmm_rdatavld) begin
            errors++;
            $display("rdatavld missing in the cycle after the read of index %0d", idx);
        end
        rd = o_cfg_avmm_rdata;
        @(negedge i_m_wr_clk);
        if (o_cfg_avmm_rdatavld) begin
            errors++;
            $display("rdatavld held longer than one cycle for index %0d", idx);
        end
    endtask

    // stops comparing while the masks and loopback change
    task automatic set_datapath(input logic [LANES:0] tx, input logic [LANES:0] rx,
                                input lpbk_mode_t mode);
        @(negedge i_m_wr_clk);
        chk_mode = MODE_OFF;
        write_reg(i_channel_id, 0, tx[31:0], 4'hf);
        write_reg(i_channel_id, 1, 32'(tx[LANES:32]), 4'hf);
        write_reg(i_channel_id, 2, rx[31:0], 4'hf);
        write_reg(i_channel_id, 3, 32'(rx[LANES:32]), 4'hf);
        write_reg(i_channel_id, 4, {30'b0, mode}, 4'hf);
        exp_tx_mask = tx;
        exp_rx_mask = rx;
    endtask

    task automatic run_traffic(input int cycles);
        repeat (cycles) begin
            @(negedge i_m_wr_clk);
            i_data_in = rand_bits(WORD);
            i_pad_rx0 = BUMPS'(rand_bits(BUMPS));
            i_pad_rx1 = BUMPS'(rand_bits(BUMPS));
        end
    endtask

    task automatic report_test(input int n, input string name);
        $display("test %0d %s finished with %0d errors", n, name, errors - err_mark);
        err_mark = errors;
    endtask

    //////////////////////////////
    // output compare
    //////////////////////////////
    always @(posedge i_m_wr_clk) begin : compare_outputs
        logic [WORD-1:0] exp_word;
        h_data[2] = h_data[1];
        h_data[1] = h_data[0];
        h_data[0] = i_data_in;
        h_rx0[1]  = h_rx0[0];
        h_rx0[0]  = i_pad_rx0;
        h_rx1[1]  = h_rx1[0];
        h_rx1[0]  = i_pad_rx1;
        h_conf[2] = h_conf[1];
        h_conf[1] = h_conf[0];
        h_conf[0] = i_conf_done;
        if (chk_mode != last_mode) begin
            warm = 0;                       // pipeline refills after a mode change
        end else if (warm < 8) begin
            warm++;
        end
        last_mode = chk_mode;
        #2;
        if (chk_mode == MODE_DIRECT) begin
            exp_word = h_conf[0] ? WORD'(tx_bump_map(split_phase(h_data[0], 0), exp_tx_mask)) : '0;
            compare_value("o_pad_tx0", WORD'(o_pad_tx0), exp_word);
            exp_word = h_conf[0] ? WORD'(tx_bump_map(split_phase(h_data[0], 1), exp_tx_mask)) : '0;
            compare_value("o_pad_tx1", WORD'(o_pad_tx1), exp_word);
            if (warm >= 1) begin
                exp_word = merge_phases(rx_lane_map(h_rx0[1], exp_rx_mask),
                                        rx_lane_map(h_rx1[1], exp_rx_mask));
                if (!h_conf[0]) begin
                    exp_word = '0;
                end
                compare_value("o_data_out", o_data_out, exp_word);
            end
        end else if (chk_mode == MODE_NEAR && warm >= 2) begin
            compare_value("o_data_out", o_data_out, h_data[2]);
        end else if (chk_mode == MODE_FAR && warm >= 1) begin
            compare_value("o_pad_tx0", WORD'(o_pad_tx0), WORD'(h_rx0[0]));
            compare_value("o_pad_tx1", WORD'(o_pad_tx1), WORD'(h_rx1[0]));
        end
    end

    //////////////////////////////
    // test sequence
    //////////////////////////////
    initial begin
        logic [31:0]        rd_word;
        logic [31:0]        wr_word;
        logic [3:0]         be_sel;
        logic [31:0]        exp_regs [0:4];
        logic [CH_ID_W-1:0] other_ch;
        logic [LANES:0]     tx_m, rx_m;
        int                 k;

        lfsr_state  = 32'h6b87163b;
        errors      = 0;
        checks      = 0;
        err_mark    = 0;
        chk_mode    = MODE_OFF;
        last_mode   = MODE_OFF;
        warm        = 0;
        exp_tx_mask = '0;
        exp_rx_mask = '0;

        i_m_wr_clk         = 1'b0;
        i_rst_n            = 1'b0;
        i_conf_done        = 1'b0;
        i_channel_id       = 6'h2d;
        i_cfg_avmm_addr    = '0;
        i_cfg_avmm_byte_en = '0;
        i_cfg_avmm_read    = 1'b0;
        i_cfg_avmm_write   = 1'b0;
        i_cfg_avmm_wdata   = '0;
        i_data_in          = '0;
        i_pad_rx0          = '0;
        i_pad_rx1          = '0;
        other_ch           = i_channel_id ^ 6'h01;
        repeat (8) @(negedge i_m_wr_clk);
        i_rst_n = 1'b1;

        // full write, partial overwrite, then a stray write to the other channel
        for (int idx = 0; idx < 5; idx++) begin
            wr_word = 32'(rand_bits(32));
            write_reg(i_channel_id, idx, wr_word, 4'hf);
            exp_regs[idx] = byte_update(32'h0, wr_word, 4'hf, impl_bits(idx));
            wr_word = 32'(rand_bits(32));
            be_sel  = (idx % 2 == 0) ? 4'b0101 : 4'b1010;
            write_reg(i_channel_id, idx, wr_word, be_sel);
            exp_regs[idx] = byte_update(exp_regs[idx], wr_word, be_sel, impl_bits(idx));
            write_reg(other_ch, idx, ~wr_word, 4'hf);
        end
        write_reg(i_channel_id, 5, 32'hffff_ffff, 4'hf);  // unmapped hole
        for (int idx = 0; idx < 5; idx++) begin
            read_reg(i_channel_id, idx, rd_word);
            compare_value($sformatf("o_cfg_avmm_rdata[%0d]", idx), WORD'(rd_word),
                          WORD'(exp_regs[idx]));
        end
        read_reg(i_channel_id, 5, rd_word);
        compare_value("o_cfg_avmm_rdata[5]", WORD'(rd_word), '0);
        read_reg(other_ch, 0, rd_word);
        compare_value("o_cfg_avmm_rdata other channel", WORD'(rd_word), '0);
        report_test(1, "register access");

        tx_m = BUMPS'(rand_bits(BUMPS));
        set_datapath(tx_m, '0, LPBK_NONE);
        i_conf_done = 1'b1;
        chk_mode    = MODE_DIRECT;
        run_traffic(40);
        report_test(2, "transmit repair");

        rx_m = BUMPS'(rand_bits(BUMPS));
        set_datapath('0, rx_m, LPBK_NONE);
        chk_mode = MODE_DIRECT;
        run_traffic(40);
        report_test(3, "receive repair");

        // matching masks around one bad bump
        k = int'(rand_bits(6)) % BUMPS;
        for (int j = 0; j <= LANES; j++) begin
            tx_m[j] = (j > k);
            rx_m[j] = (j >= k);
        end
        set_datapath(tx_m, rx_m, LPBK_NEARSIDE);
        chk_mode = MODE_NEAR;
        run_traffic(40);
        report_test(4, $sformatf("nearside loopback bad bump %0d", k));

        set_datapath('0, '0, LPBK_FARSIDE);
        chk_mode = MODE_FAR;
        run_traffic(40);
        report_test(5, "farside loopback");

        tx_m = BUMPS'(rand_bits(BUMPS));
        rx_m = BUMPS'(rand_bits(BUMPS));
        set_datapath(tx_m, rx_m, LPBK_NONE);
        i_conf_done = 1'b0;
        chk_mode    = MODE_DIRECT;
        run_traffic(12);
        i_conf_done = 1'b1;                 // data resumes from here
        run_traffic(20);
        report_test(6, "configuration not done");

        @(negedge i_m_wr_clk);
        chk_mode = MODE_OFF;
        repeat (2) @(negedge i_m_wr_clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
hw/aib_lane_pkg.sv
hw/aib_csr_regs.sv
hw/aib_tx_path.sv
hw/aib_rx_path.sv
hw/aib_pad_mux.sv
hw/aib_lane_channel.sv
tb/tb_aib_lane_channel.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the lane channel testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f filelist.f \
    --top-module tb_aib_lane_channel -Mdir obj_dir -o sim_aib_lane_channel \
    && ./obj_dir/sim_aib_lane_channel | tee sim.log \
    || { echo "build or run of the simulation failed"; exit 1; }
grep -q "TESTS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
